/* rv_decode_settings.svh */
// widths and constants of the RV64I decode stage
// included by the package and by every module of the stage
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// data and address width
`define RV_XLEN 64

// instruction width
`define RV_ILEN 32

// register file address width
`define RV_REG_AW 5

// contents of the decode/execute register while in reset
`define RV_ID_EX_RST '0

`endif

/* rv_decode_pkg.sv */
// types shared by the units of the RV64I decode stage
// operation and result-class encodings, the decoded control bundle,
// one bypass source and the decode/execute register contents
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // operation handed to execute, NOP must stay at zero
    typedef enum logic [5:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_ADDW, ALU_SUBW,
        ALU_LUI, ALU_AUIPC, ALU_LB, ALU_LH, ALU_LW, ALU_LD, ALU_LBU, ALU_LHU,
        ALU_LWU, ALU_SB, ALU_SH, ALU_SW, ALU_SD, ALU_JAL, ALU_JALR, ALU_BEQ,
        ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NONE, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_LOAD, SEL_STORE, SEL_JUMP
    } alu_sel_e;

    // SH is the zero-extended shift amount
    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SH, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef struct packed {
        alu_op_e               alu_op;
        alu_sel_e              alu_sel;
        logic                  we;
        logic [`RV_REG_AW-1:0] rd;
        logic                  rs1_read;
        logic                  rs2_read;
        logic [`RV_REG_AW-1:0] rs1_addr;
        logic [`RV_REG_AW-1:0] rs2_addr;
        imm_fmt_e              imm_fmt;
    } dec_ctrl_t;

    // write port of a later stage
    typedef struct packed {
        logic                  we;
        logic [`RV_REG_AW-1:0] addr;
        logic [`RV_XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        alu_op_e               alu_op;
        alu_sel_e              alu_sel;
        logic                  we;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        logic [`RV_XLEN-1:0]   imm;
        logic                  jump;
        logic [`RV_XLEN-1:0]   jump_addr;
    } id_ex_t;

endpackage

/* inst_decoder.sv */
// RV64I instruction decoder, purely combinational
// maps opcode, funct3 and funct7 to the operation, result class, register
// addresses, read/write enables and the immediate format
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module inst_decoder import rv_decode_pkg::*; (
    input  logic [`RV_ILEN-1:0] inst_i,
    output dec_ctrl_t           ctrl_o
);

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OPIMMW = 7'b0011011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPW    = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_ok;
    alu_op_e    op;
    alu_sel_e   sel;
    imm_fmt_e   fmt;
    logic       wr;
    logic       rd1;
    logic       rd2;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    // funct7 is either 0000000 or 0100000
    assign f7_ok  = (funct7 & 7'b1011111) == 7'b0;

    always_comb begin
        op = ALU_NOP;
        case (opcode)
            OPC_OP: begin
                case ({funct7[5], funct3})
                    4'b0000: op = ALU_ADD;
                    4'b1000: op = ALU_SUB;
                    4'b0001: op = ALU_SLL;
                    4'b0010: op = ALU_SLT;
                    4'b0011: op = ALU_SLTU;
                    4'b0100: op = ALU_XOR;
                    4'b0101: op = ALU_SRL;
                    4'b1101: op = ALU_SRA;
                    4'b0110: op = ALU_OR;
                    4'b0111: op = ALU_AND;
                    default: op = ALU_NOP;
                endcase
                if (!f7_ok) begin
                    op = ALU_NOP;
                end
            end
            OPC_OPW: begin
                case ({funct7[5], funct3})
                    4'b0000: op = ALU_ADDW;
                    4'b1000: op = ALU_SUBW;
                    4'b0001: op = ALU_SLLW;
                    4'b0101: op = ALU_SRLW;
                    4'b1101: op = ALU_SRAW;
                    default: op = ALU_NOP;
                endcase
                if (!f7_ok) begin
                    op = ALU_NOP;
                end
            end
            OPC_OPIMM: begin
                case (funct3)
                    3'd0: op = ALU_ADD;
                    3'd2: op = ALU_SLT;
                    3'd3: op = ALU_SLTU;
                    3'd4: op = ALU_XOR;
                    3'd6: op = ALU_OR;
                    3'd7: op = ALU_AND;
                    // 64-bit shifts use a 6-bit shamt, so funct6 is checked
                    3'd1: op = (inst_i[31:26] == 6'b000000) ? ALU_SLL : ALU_NOP;
                    default: begin
                        if (inst_i[31:26] == 6'b000000) begin
                            op = ALU_SRL;
                        end else if (inst_i[31:26] == 6'b010000) begin
                            op = ALU_SRA;
                        end
                    end
                endcase
            end
            OPC_OPIMMW: begin
                if (funct3 == 3'd0) begin
                    op = ALU_ADDW;
                end else if (funct3 == 3'd1 && funct7 == 7'b0) begin
                    op = ALU_SLLW;
                end else if (funct3 == 3'd5 && f7_ok) begin
                    op = funct7[5] ? ALU_SRAW : ALU_SRLW;
                end
            end
            OPC_LUI:   op = ALU_LUI;
            OPC_AUIPC: op = ALU_AUIPC;
            OPC_JAL:   op = ALU_JAL;
            OPC_JALR:  op = (funct3 == 3'd0) ? ALU_JALR : ALU_NOP;
            OPC_LOAD: begin
                case (funct3)
                    3'd0: op = ALU_LB;
                    3'd1: op = ALU_LH;
                    3'd2: op = ALU_LW;
                    3'd3: op = ALU_LD;
                    3'd4: op = ALU_LBU;
                    3'd5: op = ALU_LHU;
                    3'd6: op = ALU_LWU;
                    default: op = ALU_NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'd0: op = ALU_SB;
                    3'd1: op = ALU_SH;
                    3'd2: op = ALU_SW;
                    3'd3: op = ALU_SD;
                    default: op = ALU_NOP;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'd0: op = ALU_BEQ;
                    3'd1: op = ALU_BNE;
                    3'd4: op = ALU_BLT;
                    3'd5: op = ALU_BGE;
                    3'd6: op = ALU_BLTU;
                    3'd7: op = ALU_BGEU;
                    default: op = ALU_NOP;
                endcase
            end
            // system, fence and unknown opcodes
            default: op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (op)
            ALU_AND, ALU_OR, ALU_XOR: sel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW: sel = SEL_SHIFT;
            ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_ADDW, ALU_SUBW,
            ALU_LUI, ALU_AUIPC: sel = SEL_ARITH;
            ALU_LB, ALU_LH, ALU_LW, ALU_LD, ALU_LBU, ALU_LHU, ALU_LWU: sel = SEL_LOAD;
            ALU_SB, ALU_SH, ALU_SW, ALU_SD: sel = SEL_STORE;
            ALU_JAL, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
            ALU_BLTU, ALU_BGEU: sel = SEL_JUMP;
            default: sel = SEL_NONE;
        endcase
    end

    always_comb begin
        wr  = 1'b0;
        rd1 = 1'b0;
        rd2 = 1'b0;
        fmt = IMM_NONE;
        case (opcode)
            OPC_OP, OPC_OPW: {wr, rd1, rd2} = 3'b111;
            OPC_OPIMM, OPC_OPIMMW: begin
                {wr, rd1} = 2'b11;
                fmt = (funct3 == 3'd1 || funct3 == 3'd5) ? IMM_SH : IMM_I;
            end
            OPC_LUI, OPC_AUIPC: begin
                wr  = 1'b1;
                fmt = IMM_U;
            end
            OPC_JAL: begin
                wr  = 1'b1;
                fmt = IMM_J;
            end
            OPC_JALR, OPC_LOAD: begin
                {wr, rd1} = 2'b11;
                fmt = IMM_I;
            end
            OPC_STORE: begin
                {rd1, rd2} = 2'b11;
                fmt = IMM_S;
            end
            OPC_BRANCH: begin
                {rd1, rd2} = 2'b11;
                fmt = IMM_B;
            end
            default: fmt = IMM_NONE;
        endcase
        // invalid encodings enable nothing
        if (op == ALU_NOP) begin
            {wr, rd1, rd2} = 3'b000;
            fmt = IMM_NONE;
        end
    end

    // writes to x0 are dropped here so later stages never see them
    always_comb begin
        ctrl_o.alu_op   = op;
        ctrl_o.alu_sel  = sel;
        ctrl_o.we       = wr && (inst_i[11:7] != '0);
        ctrl_o.rd       = ctrl_o.we ? inst_i[11:7] : '0;
        ctrl_o.rs1_read = rd1;
        ctrl_o.rs2_read = rd2;
        ctrl_o.rs1_addr = inst_i[19:15];
        ctrl_o.rs2_addr = inst_i[24:20];
        ctrl_o.imm_fmt  = fmt;
    end

endmodule

/* imm_gen.sv */
// immediate generator for the RV64I formats
// gathers the scattered immediate bits and extends them to XLEN,
// sign-extended from bit 31 except for the shift amount
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module imm_gen import rv_decode_pkg::*; (
    input  logic [`RV_ILEN-1:0] inst_i,
    input  imm_fmt_e            fmt_i,
    output logic [`RV_XLEN-1:0] imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{(`RV_XLEN-12){sign}}, inst_i[31:20]};
            end
            // 6-bit shamt, W shifts leave bit 25 clear
            IMM_SH: begin
                imm_o = {{(`RV_XLEN-6){1'b0}}, inst_i[25:20]};
            end
            IMM_S: begin
                imm_o = {{(`RV_XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{(`RV_XLEN-13){sign}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {{(`RV_XLEN-32){sign}}, inst_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{(`RV_XLEN-21){sign}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

/* operand_forward.sv */
// source operand select for one register operand
// a read operand takes the execute bypass, then the memory bypass, then
// the register file; x0 is never bypassed
// an unread operand takes alt_i (immediate for rs1, zero for rs2)
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module operand_forward import rv_decode_pkg::*; (
    input  logic                  read_i,
    input  logic [`RV_REG_AW-1:0] addr_i,
    input  logic [`RV_XLEN-1:0]   rf_data_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  mem_fwd_i,
    input  logic [`RV_XLEN-1:0]   alt_i,
    output logic [`RV_XLEN-1:0]   operand_o
);

    logic nonzero;
    logic ex_hit;
    logic mem_hit;

    assign nonzero = addr_i != '0;
    assign ex_hit  = nonzero && ex_fwd_i.we && (ex_fwd_i.addr == addr_i);
    assign mem_hit = nonzero && mem_fwd_i.we && (mem_fwd_i.addr == addr_i);

    // execute holds the younger result, so it wins over memory
    always_comb begin
        if (!read_i) begin
            operand_o = alt_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

/* branch_unit.sv */
// branch resolution in decode
// compares the forwarded operands for the six conditional branches and
// produces the jump flag and target; JAL and JALR are always taken
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module branch_unit import rv_decode_pkg::*; (
    input  alu_op_e             op_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] imm_i,
    input  logic [`RV_XLEN-1:0] rs1_i,
    input  logic [`RV_XLEN-1:0] rs2_i,
    output logic                jump_o,
    output logic [`RV_XLEN-1:0] jump_addr_o
);

    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic                taken;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] reg_sum;

    assign eq        = rs1_i == rs2_i;
    assign lt_s      = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u      = rs1_i < rs2_i;
    assign pc_target = pc_i + imm_i;
    assign reg_sum   = rs1_i + imm_i;

    always_comb begin
        case (op_i)
            ALU_BEQ:  taken = eq;
            ALU_BNE:  taken = !eq;
            ALU_BLT:  taken = lt_s;
            ALU_BGE:  taken = !lt_s;
            ALU_BLTU: taken = lt_u;
            ALU_BGEU: taken = !lt_u;
            ALU_JAL, ALU_JALR: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign jump_o = taken;

    // JALR clears bit 0 of rs1 + imm
    always_comb begin
        if (!taken) begin
            jump_addr_o = '0;
        end else if (op_i == ALU_JALR) begin
            jump_addr_o = {reg_sum[`RV_XLEN-1:1], 1'b0};
        end else begin
            jump_addr_o = pc_target;
        end
    end

endmodule

/* id_stage.sv */
// decode stage of the RV64I pipeline
// register-file requests leave combinationally from the current instruction;
// the decoded bundle reaches execute through one register, one cycle later
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module id_stage import rv_decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [`RV_ILEN-1:0]   inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   reg1_data_i,
    input  logic [`RV_XLEN-1:0]   reg2_data_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  mem_fwd_i,
    output logic                  reg1_read_o,
    output logic                  reg2_read_o,
    output logic [`RV_REG_AW-1:0] reg1_addr_o,
    output logic [`RV_REG_AW-1:0] reg2_addr_o,
    output id_ex_t                id_ex_o
);

    dec_ctrl_t           ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic                jump;
    logic [`RV_XLEN-1:0] jump_addr;
    id_ex_t              id_ex_d;
    id_ex_t              id_ex_q;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    imm_gen u_imm_gen (
        .inst_i (inst_i),
        .fmt_i  (ctrl.imm_fmt),
        .imm_o  (imm)
    );

    // operand 1 falls back to the immediate (LUI, AUIPC, JAL)
    operand_forward u_fwd_rs1 (
        .read_i    (ctrl.rs1_read),
        .addr_i    (ctrl.rs1_addr),
        .rf_data_i (reg1_data_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .alt_i     (imm),
        .operand_o (op1)
    );

    operand_forward u_fwd_rs2 (
        .read_i    (ctrl.rs2_read),
        .addr_i    (ctrl.rs2_addr),
        .rf_data_i (reg2_data_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .alt_i     ('0),
        .operand_o (op2)
    );

    branch_unit u_branch (
        .op_i        (ctrl.alu_op),
        .pc_i        (pc_i),
        .imm_i       (imm),
        .rs1_i       (op1),
        .rs2_i       (op2),
        .jump_o      (jump),
        .jump_addr_o (jump_addr)
    );

    assign reg1_read_o = ctrl.rs1_read;
    assign reg2_read_o = ctrl.rs2_read;
    assign reg1_addr_o = ctrl.rs1_addr;
    assign reg2_addr_o = ctrl.rs2_addr;

    always_comb begin
        id_ex_d.alu_op    = ctrl.alu_op;
        id_ex_d.alu_sel   = ctrl.alu_sel;
        id_ex_d.we        = ctrl.we;
        id_ex_d.rd        = ctrl.rd;
        id_ex_d.op1       = op1;
        id_ex_d.op2       = op2;
        id_ex_d.imm       = imm;
        id_ex_d.jump      = jump;
        id_ex_d.jump_addr = jump_addr;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q <= `RV_ID_EX_RST;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* id_stage_props.sv */
// concurrent checks on the decode/execute register of id_stage
// attached to every id_stage instance through the bind at the end
`timescale 1ns/1ps

module id_stage_props import rv_decode_pkg::*; (
    input logic   clk,
    input logic   reset_i,
    input id_ex_t id_ex_o
);

    int fail_cnt = 0;

    // register is clear one edge after reset is seen
    a_reset_clear: assert property (@(posedge clk) reset_i |=> id_ex_o == '0)
        else begin
            fail_cnt++;
            $error("id_ex_o not cleared after reset");
        end

    a_jump_class: assert property (@(posedge clk) disable iff (reset_i)
        id_ex_o.jump |-> id_ex_o.alu_sel == SEL_JUMP)
        else begin
            fail_cnt++;
            $error("jump set without result class JUMP");
        end

    a_jump_even: assert property (@(posedge clk) disable iff (reset_i)
        id_ex_o.jump |-> id_ex_o.jump_addr[0] == 1'b0)
        else begin
            fail_cnt++;
            $error("jump target is odd");
        end

endmodule

bind id_stage id_stage_props u_props (
    .clk     (clk),
    .reset_i (reset_i),
    .id_ex_o (id_ex_o)
);

/* id_stage_tb.sv */
// testbench for the RV64I decode stage
// directed tests drive id_stage on the falling edge and check id_ex_o one
// rising edge later against a model of the immediate, forwarding and branch rules
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module id_stage_tb import rv_decode_pkg::*; ();

    localparam logic [63:0] PC_BASE     = 64'h0000_0000_8000_0000;
    localparam int          WATCHDOG_NS = 6 * 64 * 8 + 8 * 8;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic [`RV_ILEN-1:0]   inst_i;
    logic [`RV_XLEN-1:0]   pc_i;
    logic [`RV_XLEN-1:0]   reg1_data_i;
    logic [`RV_XLEN-1:0]   reg2_data_i;
    fwd_t                  ex_fwd_i;
    fwd_t                  mem_fwd_i;
    logic                  reg1_read_o;
    logic                  reg2_read_o;
    logic [`RV_REG_AW-1:0] reg1_addr_o;
    logic [`RV_REG_AW-1:0] reg2_addr_o;
    id_ex_t                id_ex_o;

    // stimulus for the next instruction, applied by run
    logic [63:0] rf1_v = '0;
    logic [63:0] rf2_v = '0;
    fwd_t        ex_v  = '0;
    fwd_t        mem_v = '0;

    int tests     = 0;
    int checks    = 0;
    int errors    = 0;
    int test_errs = 0;
    int total;

    id_stage UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .id_ex_o     (id_ex_o)
    );

    always #4 clk = ~clk;

    function automatic logic [63:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [63:0] sx(input logic [63:0] v, input int bits);
        logic [63:0] t;
        t = v << (64 - bits);
        return $signed(t) >>> (64 - bits);
    endfunction

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    // bypass priority, execute before memory, never for x0
    function automatic logic [63:0] fwd_model(input logic rd, input logic [4:0] a,
                                              input logic [63:0] rf, input logic [63:0] alt);
        if (!rd) begin
            return alt;
        end
        if (a != 5'd0 && ex_v.we && ex_v.addr == a) begin
            return ex_v.data;
        end
        if (a != 5'd0 && mem_v.we && mem_v.addr == a) begin
            return mem_v.data;
        end
        return rf;
    endfunction

    // returns {jump, target}
    function automatic logic [64:0] branch_model(input alu_op_e op, input logic [63:0] p,
                                                 input logic [63:0] imm,
                                                 input logic [63:0] a, input logic [63:0] b);
        logic        t;
        logic [63:0] tgt;
        tgt = p + imm;
        case (op)
            ALU_BEQ:  t = a == b;
            ALU_BNE:  t = a != b;
            ALU_BLT:  t = $signed(a) < $signed(b);
            ALU_BGE:  t = $signed(a) >= $signed(b);
            ALU_BLTU: t = a < b;
            ALU_BGEU: t = a >= b;
            ALU_JAL:  t = 1'b1;
            ALU_JALR: begin
                t   = 1'b1;
                tgt = (a + imm) & ~64'd1;
            end
            default:  t = 1'b0;
        endcase
        return t ? {1'b1, tgt} : 65'd0;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    task automatic randomize_rf();
        rf1_v = rnd64();
        rf2_v = rnd64();
    endtask

    task automatic set_fwd(input logic ew, input logic [4:0] ea,
                           input logic mw, input logic [4:0] ma);
        ex_v  = {ew, ea, rnd64()};
        mem_v = {mw, ma, rnd64()};
    endtask

    // one instruction per cycle; wrr is {write, read rs1, read rs2}
    task automatic run(input logic [31:0] in, input logic [63:0] p, input alu_op_e op,
                       input alu_sel_e sel, input logic [2:0] wrr, input logic [63:0] imm_e);
        logic [63:0] a;
        logic [63:0] b;
        logic [64:0] br;
        @(negedge clk);
        inst_i      = in;
        pc_i        = p;
        reg1_data_i = rf1_v;
        reg2_data_i = rf2_v;
        ex_fwd_i    = ex_v;
        mem_fwd_i   = mem_v;
        a  = fwd_model(wrr[1], in[19:15], rf1_v, imm_e);
        b  = fwd_model(wrr[0], in[24:20], rf2_v, 64'd0);
        br = branch_model(op, p, imm_e, a, b);
        #1;
        check("reg1_read_o", reg1_read_o, wrr[1]);
        check("reg2_read_o", reg2_read_o, wrr[0]);
        check("reg1_addr_o", reg1_addr_o, in[19:15]);
        check("reg2_addr_o", reg2_addr_o, in[24:20]);
        @(posedge clk);
        #1;
        check("alu_op", id_ex_o.alu_op, op);
        check("alu_sel", id_ex_o.alu_sel, sel);
        check("we", id_ex_o.we, wrr[2]);
        check("rd", id_ex_o.rd, wrr[2] ? in[11:7] : 5'd0);
        check("imm", id_ex_o.imm, imm_e);
        check("op1", id_ex_o.op1, a);
        check("op2", id_ex_o.op2, b);
        check("jump", id_ex_o.jump, br[64]);
        check("jump_addr", id_ex_o.jump_addr, br[63:0]);
    endtask

    task automatic test_reset();
        int i;
        // an ADDI sits on the input while reset holds the register clear
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            checks++;
            if (id_ex_o !== '0) begin
                $display("error id_ex_o: got %h, expected 0", id_ex_o);
                errors++;
                test_errs++;
            end
        end
        @(negedge clk);
        reset_i = 1'b0;
        rf1_v = '0;
        rf2_v = '0;
        run(32'h0000_0013, PC_BASE, ALU_ADD, SEL_ARITH, 3'b010, 64'd0);
        run(32'h0000_0073, PC_BASE, ALU_NOP, SEL_NONE, 3'b000, 64'd0);
        run(32'h0010_0073, PC_BASE, ALU_NOP, SEL_NONE, 3'b000, 64'd0);
        run(32'h0FF0_000F, PC_BASE, ALU_NOP, SEL_NONE, 3'b000, 64'd0);
        run(32'hFFFF_FFFF, PC_BASE, ALU_NOP, SEL_NONE, 3'b000, 64'd0);
        finish_test("reset");
    endtask

    task automatic test_alu();
        randomize_rf();
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        run(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b111, 64'd0);
        run(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_SUB, SEL_ARITH,
            3'b111, 64'd0);
        run(enc_r(7'h20, 5'd12, 5'd11, 3'd5, 5'd13, 7'h33), PC_BASE, ALU_SRA, SEL_SHIFT,
            3'b111, 64'd0);
        run(enc_r(7'h00, 5'd4, 5'd5, 3'd7, 5'd6, 7'h33), PC_BASE, ALU_AND, SEL_LOGIC,
            3'b111, 64'd0);
        run(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h3B), PC_BASE, ALU_SUBW, SEL_ARITH,
            3'b111, 64'd0);
        randomize_rf();
        run(enc_i(12'hFFB, 5'd1, 3'd0, 5'd4, 7'h13), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b110, sx(64'hFFB, 12));
        run(enc_i(12'h800, 5'd1, 3'd2, 5'd4, 7'h13), PC_BASE, ALU_SLT, SEL_ARITH,
            3'b110, sx(64'h800, 12));
        run(enc_i(12'h7FF, 5'd1, 3'd3, 5'd4, 7'h13), PC_BASE, ALU_SLTU, SEL_ARITH,
            3'b110, 64'h7FF);
        run(enc_i(12'hA5A, 5'd1, 3'd4, 5'd4, 7'h13), PC_BASE, ALU_XOR, SEL_LOGIC,
            3'b110, sx(64'hA5A, 12));
        // shift amounts are zero-extended
        run(enc_i(12'h43F, 5'd1, 3'd5, 5'd6, 7'h13), PC_BASE, ALU_SRA, SEL_SHIFT,
            3'b110, 64'd63);
        run(enc_i(12'h021, 5'd1, 3'd1, 5'd6, 7'h13), PC_BASE, ALU_SLL, SEL_SHIFT,
            3'b110, 64'd33);
        run(enc_i(12'h007, 5'd1, 3'd5, 5'd6, 7'h1B), PC_BASE, ALU_SRLW, SEL_SHIFT,
            3'b110, 64'd7);
        run(enc_i(12'h9C4, 5'd1, 3'd0, 5'd6, 7'h1B), PC_BASE, ALU_ADDW, SEL_ARITH,
            3'b110, sx(64'h9C4, 12));
        run({20'h80001, 5'd7, 7'h37}, PC_BASE, ALU_LUI, SEL_ARITH, 3'b100,
            64'hFFFF_FFFF_8000_1000);
        run({20'h12345, 5'd8, 7'h17}, PC_BASE, ALU_AUIPC, SEL_ARITH, 3'b100,
            64'h0000_0000_1234_5000);
        finish_test("alu");
    endtask

    task automatic test_forward();
        randomize_rf();
        // both stages hold x1
        set_fwd(1'b1, 5'd1, 1'b1, 5'd1);
        run(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b111, 64'd0);
        set_fwd(1'b1, 5'd9, 1'b1, 5'd2);
        run(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b111, 64'd0);
        set_fwd(1'b0, 5'd1, 1'b0, 5'd2);
        run(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b111, 64'd0);
        set_fwd(1'b1, 5'd0, 1'b1, 5'd0);
        run(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b111, 64'd0);
        set_fwd(1'b1, 5'd20, 1'b1, 5'd21);
        run(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33), PC_BASE, ALU_ADD, SEL_ARITH,
            3'b111, 64'd0);
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        finish_test("forward");
    endtask

    task automatic test_branch();
        logic [63:0] pa [6];
        logic [63:0] pb [6];
        logic [2:0]  f3;
        logic [12:0] off;
        alu_op_e     op;
        int          i;
        int          j;
        pa[0] = 64'd5;
        pb[0] = 64'd5;
        pa[1] = '1;
        pb[1] = 64'd1;
        pa[2] = 64'd1;
        pb[2] = '1;
        pa[3] = 64'h8000_0000_0000_0000;
        pb[3] = 64'h7FFF_FFFF_FFFF_FFFF;
        pa[4] = rnd64();
        pb[4] = pa[4];
        pa[5] = rnd64();
        pb[5] = rnd64();
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        // consecutive run calls put the branches back to back
        for (i = 0; i < 6; i++) begin
            case (i)
                0: op = ALU_BEQ;
                1: op = ALU_BNE;
                2: op = ALU_BLT;
                3: op = ALU_BGE;
                4: op = ALU_BLTU;
                default: op = ALU_BGEU;
            endcase
            f3 = (i < 2) ? i : i + 2;
            for (j = 0; j < 6; j++) begin
                off   = j[0] ? 13'h1FF0 : 13'h0824;
                rf1_v = pa[j];
                rf2_v = pb[j];
                run(enc_b(off, 5'd2, 5'd1, f3), PC_BASE + i * 64 + j * 4, op, SEL_JUMP,
                    3'b011, sx(off, 13));
            end
        end
        finish_test("branch");
    endtask

    task automatic test_jump();
        randomize_rf();
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        run(enc_j(21'h1FFFF0, 5'd1), PC_BASE + 64'h400, ALU_JAL, SEL_JUMP, 3'b100,
            sx(64'h1FFFF0, 21));
        run(enc_j(21'h0AAAAA, 5'd1), PC_BASE + 64'h404, ALU_JAL, SEL_JUMP, 3'b100,
            64'h0AAAAA);
        run(enc_i(12'h7FF, 5'd1, 3'd0, 5'd5, 7'h67), PC_BASE, ALU_JALR, SEL_JUMP,
            3'b110, 64'h7FF);
        // rs1 comes from the execute bypass
        set_fwd(1'b1, 5'd1, 1'b0, 5'd0);
        run(enc_i(12'h801, 5'd1, 3'd0, 5'd5, 7'h67), PC_BASE, ALU_JALR, SEL_JUMP,
            3'b110, sx(64'h801, 12));
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        finish_test("jump");
    endtask

    task automatic test_mem();
        randomize_rf();
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        run(enc_i(12'hFF8, 5'd2, 3'd3, 5'd9, 7'h03), PC_BASE, ALU_LD, SEL_LOAD,
            3'b110, sx(64'hFF8, 12));
        run(enc_i(12'h7F0, 5'd2, 3'd4, 5'd9, 7'h03), PC_BASE, ALU_LBU, SEL_LOAD,
            3'b110, 64'h7F0);
        run(enc_i(12'h804, 5'd2, 3'd6, 5'd10, 7'h03), PC_BASE, ALU_LWU, SEL_LOAD,
            3'b110, sx(64'h804, 12));
        run(enc_s(12'h800, 5'd3, 5'd4, 3'd3), PC_BASE, ALU_SD, SEL_STORE,
            3'b011, sx(64'h800, 12));
        run(enc_s(12'h123, 5'd3, 5'd4, 3'd0), PC_BASE, ALU_SB, SEL_STORE,
            3'b011, 64'h123);
        run(enc_s(12'hFFC, 5'd5, 5'd6, 3'd2), PC_BASE, ALU_SW, SEL_STORE,
            3'b011, sx(64'hFFC, 12));
        finish_test("mem");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(17));
        reset_i     = 1'b1;
        inst_i      = enc_i(12'h001, 5'd1, 3'd0, 5'd5, 7'h13);
        pc_i        = PC_BASE;
        reg1_data_i = '1;
        reg2_data_i = '1;
        ex_fwd_i    = '0;
        mem_fwd_i   = '0;
        test_reset();
        test_alu();
        test_forward();
        test_branch();
        test_jump();
        test_mem();
        total = errors + UUT.u_props.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
rv_decode_pkg.sv
inst_decoder.sv
imm_gen.sv
operand_forward.sv
branch_unit.sv
id_stage.sv
id_stage_props.sv
id_stage_tb.sv

/* Bender.yml */
package:
  name: rv_id_stage

sources:
  - include_dirs:
      - .
    files:
      - rv_decode_pkg.sv
      - inst_decoder.sv
      - imm_gen.sv
      - operand_forward.sv
      - branch_unit.sv
      - id_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - id_stage_props.sv
      - id_stage_tb.sv
